// ==== rtl/wisc_consts.svh ====
// WISC decode constants
// Sizes shared by the instruction set types, the control types,
// the register file and the stage top

`ifndef WISC_CONSTS_SVH
`define WISC_CONSTS_SVH

// Width of a data word and of an instruction word
`define WISC_DATA_W 16

// Number of general registers
`define WISC_NREGS 8

// Bits needed to select one general register
`define WISC_RSEL_W 3

// Opcode field at the top of every instruction
`define WISC_OPC_W 5

`endif

// ==== rtl/isaPkg.sv ====
// WISC instruction set types
// Opcode encoding and the four ways an instruction word is read

`include "wisc_consts.svh"

package isaPkg;

   // One name per opcode, grouped by the top opcode bits
   typedef enum logic [`WISC_OPC_W-1:0] {
      // Machine control and jumps
      opHalt  = 5'b00000, opNop   = 5'b00001, opSiic  = 5'b00010, opRti   = 5'b00011,
      opJ     = 5'b00100, opJr    = 5'b00101, opJal   = 5'b00110, opJalr  = 5'b00111,
      // Immediate arithmetic and branches against zero
      opAddi  = 5'b01000, opSubi  = 5'b01001, opXori  = 5'b01010, opAndni = 5'b01011,
      opBeqz  = 5'b01100, opBnez  = 5'b01101, opBltz  = 5'b01110, opBgez  = 5'b01111,
      // Memory and shifts by immediate
      opSt    = 5'b10000, opLd    = 5'b10001, opSlbi  = 5'b10010, opStu   = 5'b10011,
      opRoli  = 5'b10100, opSlli  = 5'b10101, opRori  = 5'b10110, opSrli  = 5'b10111,
      // Register forms, funct picks the operation for opShift and opArith
      opLbi   = 5'b11000, opBtr   = 5'b11001, opShift = 5'b11010, opArith = 5'b11011,
      opSeq   = 5'b11100, opSlt   = 5'b11101, opSle   = 5'b11110, opSco   = 5'b11111
   } opcodeE;

   // Instruction word, each view covers all sixteen bits
   typedef union packed {
      // Register form
      struct packed {
         opcodeE                  opcode;
         logic [`WISC_RSEL_W-1:0] rs;
         logic [`WISC_RSEL_W-1:0] rt;
         logic [`WISC_RSEL_W-1:0] rd;
         logic [1:0]              funct;
      } rFmt;
      // Short immediate form, rd sits where rt is in the register form
      struct packed {
         opcodeE                  opcode;
         logic [`WISC_RSEL_W-1:0] rs;
         logic [`WISC_RSEL_W-1:0] rd;
         logic [4:0]              imm5;
      } iFmt1;
      // Long immediate form for branches, LBI, SLBI and register jumps
      struct packed {
         opcodeE                  opcode;
         logic [`WISC_RSEL_W-1:0] rs;
         logic [7:0]              imm8;
      } iFmt2;
      // PC relative jumps
      struct packed {
         opcodeE      opcode;
         logic [10:0] disp11;
      } jFmt;
   } instU;

endpackage

// ==== rtl/ctrlPkg.sv ====
// Decode stage output types
// Selector encodings, the control bundle and the decoded operation
// handed to execute

`include "wisc_consts.svh"

package ctrlPkg;

   // ALU B operand source
   typedef enum logic [1:0] {
      bSrcRt   = 2'b00,
      bSrcImm5 = 2'b01,
      bSrcImm8 = 2'b10,
      bSrcZero = 2'b11
   } bSrcE;

   // Which instruction field names the destination register
   typedef enum logic [1:0] {
      regDstRd = 2'b00,
      regDstRs = 2'b01,
      regDstRt = 2'b10,
      regDstR7 = 2'b11
   } regDstE;

   // Writeback data source
   typedef enum logic [1:0] {
      regSrcPc  = 2'b00,
      regSrcMem = 2'b01,
      regSrcAlu = 2'b10,
      regSrcB   = 2'b11
   } regSrcE;

   // Control bundle, PC and memory flags first, ALU fields after
   typedef struct packed {
      logic       immSrc;
      logic       aluJump;
      logic       memWrite;
      logic       regWrite;
      logic       invA;
      logic       invB;
      logic       cin;
      logic       signedCmp;
      logic [2:0] brType;
      logic [3:0] oper;
      bSrcE       bSrc;
      regDstE     regDst;
      regSrcE     regSrc;
   } ctrlT;

   // Everything execute needs for one instruction
   typedef struct packed {
      ctrlT                    ctrl;
      logic [`WISC_DATA_W-1:0] r1Data;
      logic [`WISC_DATA_W-1:0] r2Data;
      logic [`WISC_DATA_W-1:0] imm5Ext;
      logic [`WISC_DATA_W-1:0] imm8Ext;
      logic [`WISC_DATA_W-1:0] imm11Ext;
      logic [`WISC_RSEL_W-1:0] rdSel;
      logic [`WISC_RSEL_W-1:0] rsSel;
   } decOpT;

endpackage

// ==== rtl/ctrlDecoder.sv ====
// WISC control decoder
// Turns the opcode, and funct for register forms, into the control
// bundle and the immediate extension mode. Purely combinational
`timescale 1ns/100ps

module ctrlDecoder (
   input  isaPkg::opcodeE opc,
   input  logic [1:0]     funct,
   output ctrlPkg::ctrlT  ctrl,
   output logic           zeroExt
);

   // ALU operation codes, shifts use 00 and the shift type
   localparam logic [3:0] aluAdd = 4'b0100;
   localparam logic [3:0] aluAnd = 4'b0101;
   localparam logic [3:0] aluXor = 4'b0111;
   localparam logic [3:0] aluCmp = 4'b1100;

   ////////////////////
   // Control bundle
   ////////////////////
   always_comb begin
      // Plain ALU op writing rd is the common case
      ctrl           = '0;
      ctrl.regWrite  = 1'b1;
      ctrl.oper      = aluAdd;
      ctrl.bSrc      = ctrlPkg::bSrcImm8;
      ctrl.regDst    = ctrlPkg::regDstRd;
      ctrl.regSrc    = ctrlPkg::regSrcAlu;
      // Low opcode bits pick branch condition or compare type
      ctrl.brType    = {1'b0, opc[1:0]};
      unique case (opc)
         isaPkg::opHalt, isaPkg::opNop, isaPkg::opSiic, isaPkg::opRti: begin
            ctrl.regWrite = 1'b0;
         end
         // PC relative jumps take disp11
         isaPkg::opJ, isaPkg::opJal: begin
            ctrl.immSrc   = 1'b1;
            ctrl.regWrite = (opc == isaPkg::opJal);
            ctrl.regDst   = ctrlPkg::regDstR7;
            ctrl.regSrc   = ctrlPkg::regSrcPc;
         end
         // Register jumps go through the ALU, rs plus imm8
         isaPkg::opJr, isaPkg::opJalr: begin
            ctrl.aluJump  = 1'b1;
            ctrl.regWrite = (opc == isaPkg::opJalr);
            ctrl.regDst   = ctrlPkg::regDstR7;
            ctrl.regSrc   = ctrlPkg::regSrcPc;
         end
         isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndni: begin
            ctrl.bSrc   = ctrlPkg::bSrcImm5;
            ctrl.regDst = ctrlPkg::regDstRt;
            ctrl.oper   = (opc == isaPkg::opXori)  ? aluXor :
                          (opc == isaPkg::opAndni) ? aluAnd : aluAdd;
            // SUBI is imm minus rs
            ctrl.invA   = (opc == isaPkg::opSubi);
            ctrl.invB   = (opc == isaPkg::opAndni);
            ctrl.cin    = (opc == isaPkg::opSubi) || (opc == isaPkg::opAndni);
         end
         // Branches compare rs against zero
         isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opBltz, isaPkg::opBgez: begin
            ctrl.aluJump   = 1'b1;
            ctrl.regWrite  = 1'b0;
            ctrl.signedCmp = 1'b1;
            ctrl.brType[2] = 1'b1;
            ctrl.bSrc      = ctrlPkg::bSrcZero;
         end
         // STU also writes the updated address back to rs
         isaPkg::opSt, isaPkg::opStu: begin
            ctrl.memWrite = 1'b1;
            ctrl.regWrite = (opc == isaPkg::opStu);
            ctrl.bSrc     = ctrlPkg::bSrcImm5;
            ctrl.regDst   = ctrlPkg::regDstRs;
         end
         isaPkg::opLd: begin
            ctrl.bSrc   = ctrlPkg::bSrcImm5;
            ctrl.regDst = ctrlPkg::regDstRt;
            ctrl.regSrc = ctrlPkg::regSrcMem;
         end
         // Load immediates land in rs
         isaPkg::opSlbi, isaPkg::opLbi: begin
            ctrl.regDst = ctrlPkg::regDstRs;
            ctrl.regSrc = ctrlPkg::regSrcB;
         end
         isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
            ctrl.bSrc   = ctrlPkg::bSrcImm5;
            ctrl.regDst = ctrlPkg::regDstRt;
            ctrl.oper   = {2'b00, opc[1:0]};
         end
         isaPkg::opBtr: begin
            ctrl.regSrc = ctrlPkg::regSrcB;
         end
         isaPkg::opShift: begin
            ctrl.bSrc = ctrlPkg::bSrcRt;
            ctrl.oper = {2'b00, funct};
         end
         // funct 00 ADD, 01 SUB, 10 XOR, 11 ANDN
         isaPkg::opArith: begin
            ctrl.bSrc = ctrlPkg::bSrcRt;
            ctrl.oper = funct[1] ? (funct[0] ? aluAnd : aluXor) : aluAdd;
            ctrl.invA = (funct == 2'b01);
            ctrl.invB = (funct == 2'b11);
            ctrl.cin  = funct[0];
         end
         // SEQ and SLT subtract rs, SLE subtracts rt
         isaPkg::opSeq, isaPkg::opSlt, isaPkg::opSle, isaPkg::opSco: begin
            ctrl.bSrc = ctrlPkg::bSrcRt;
            ctrl.oper = aluCmp;
            ctrl.invA = (opc == isaPkg::opSeq) || (opc == isaPkg::opSlt);
            ctrl.invB = (opc == isaPkg::opSle);
            ctrl.cin  = (opc != isaPkg::opSco);
         end
      endcase
   end

   // Logical immediates are zero extended
   assign zeroExt = (opc == isaPkg::opSlbi) || (opc == isaPkg::opXori) ||
                    (opc == isaPkg::opAndni);

   ////////////////////
   // Checks
   ////////////////////
   always_comb begin
      if (!$isunknown(opc)) begin
         ctrlKnownA: assert final (!$isunknown({ctrl, zeroExt}))
            else $error("ctrlDecoder unknown control for opcode %b", opc);
      end
      // Carry in per opcode must agree with the inversions
      cinA: assert final (ctrl.cin == (ctrl.invA | ctrl.invB))
         else $error("ctrlDecoder cin mismatch for opcode %b", opc);
   end

endmodule

// ==== rtl/regFile.sv ====
// General register file
// Eight registers, two combinational read ports and one write port
// Same-cycle writes are bypassed to the read ports
`timescale 1ns/100ps

`include "wisc_consts.svh"

module regFile (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [`WISC_RSEL_W-1:0] rd1Sel,
   input  logic [`WISC_RSEL_W-1:0] rd2Sel,
   input  logic [`WISC_RSEL_W-1:0] wrSel,
   input  logic                    wrEn,
   input  logic [`WISC_DATA_W-1:0] wrData,
   output logic [`WISC_DATA_W-1:0] rd1Data,
   output logic [`WISC_DATA_W-1:0] rd2Data
);

   // Register storage
   logic [`WISC_DATA_W-1:0] regs [`WISC_NREGS];

   // Bypass hits per read port
   logic hit1;
   logic hit2;

   ////////////////////
   // Write port
   ////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         // All registers read zero after reset
         for (int i = 0; i < `WISC_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrSel] <= wrData;
      end
   end

   ////////////////////
   // Read ports
   ////////////////////
   assign hit1 = wrEn && (wrSel == rd1Sel);
   assign hit2 = wrEn && (wrSel == rd2Sel);

   // New data wins over the stored copy
   assign rd1Data = hit1 ? wrData : regs[rd1Sel];
   assign rd2Data = hit2 ? wrData : regs[rd2Sel];

   // A write with an unknown select would corrupt an unknown register
   wrSelKnownA: assert property (@(posedge clk) disable iff (!rstN)
      wrEn |-> !$isunknown(wrSel))
      else $error("regFile write with unknown select");

endmodule

// ==== rtl/wiscDecode.sv ====
// WISC decode stage
// Takes one instruction per valid/ready handshake, decodes control,
// reads both source registers and extends the immediates. The result
// sits in an output register with its own valid/ready. The writeback
// port updates the register file and is always accepted
`timescale 1ns/100ps

`include "wisc_consts.svh"

module wiscDecode (
   input  logic                    clk,
   input  logic                    rstN,
   // Instruction in
   input  logic                    instValid,
   output logic                    instReady,
   input  isaPkg::instU            inst,
   // Writeback from later stages
   input  logic                    wbEn,
   input  logic [`WISC_RSEL_W-1:0] wbSel,
   input  logic [`WISC_DATA_W-1:0] wbData,
   // Decoded operation out
   output logic                    decValid,
   input  logic                    decReady,
   output ctrlPkg::decOpT          dec
);

   ctrlPkg::ctrlT           ctrl;
   logic                    zeroExt;
   logic [`WISC_DATA_W-1:0] r1Data;
   logic [`WISC_DATA_W-1:0] r2Data;
   logic [`WISC_RSEL_W-1:0] rdSel;
   ctrlPkg::decOpT          decNext;
   logic                    accept;

   ////////////////////
   // Decode and read
   ////////////////////
   ctrlDecoder u_ctrlDecoder (
      .opc     (inst.rFmt.opcode),
      .funct   (inst.rFmt.funct),
      .ctrl    (ctrl),
      .zeroExt (zeroExt)
   );

   // rs and rt fields sit at the same place in every format
   regFile u_regFile (
      .clk     (clk),
      .rstN    (rstN),
      .rd1Sel  (inst.rFmt.rs),
      .rd2Sel  (inst.rFmt.rt),
      .wrSel   (wbSel),
      .wrEn    (wbEn),
      .wrData  (wbData),
      .rd1Data (r1Data),
      .rd2Data (r2Data)
   );

   // Resolve the destination register number
   always_comb begin
      unique case (ctrl.regDst)
         ctrlPkg::regDstRd: rdSel = inst.rFmt.rd;
         ctrlPkg::regDstRs: rdSel = inst.rFmt.rs;
         ctrlPkg::regDstRt: rdSel = inst.iFmt1.rd;
         ctrlPkg::regDstR7: rdSel = `WISC_RSEL_W'(`WISC_NREGS - 1);
      endcase
   end

   // Immediates, disp11 is always signed
   always_comb begin
      decNext.ctrl     = ctrl;
      decNext.r1Data   = r1Data;
      decNext.r2Data   = r2Data;
      decNext.imm5Ext  = {{(`WISC_DATA_W - 5){inst.iFmt1.imm5[4] & ~zeroExt}},
                          inst.iFmt1.imm5};
      decNext.imm8Ext  = {{(`WISC_DATA_W - 8){inst.iFmt2.imm8[7] & ~zeroExt}},
                          inst.iFmt2.imm8};
      decNext.imm11Ext = {{(`WISC_DATA_W - 11){inst.jFmt.disp11[10]}}, inst.jFmt.disp11};
      decNext.rdSel    = rdSel;
      decNext.rsSel    = inst.rFmt.rs;
   end

   ////////////////////
   // Output register
   ////////////////////
   // Free when empty or draining this cycle
   assign instReady = !decValid || decReady;
   assign accept    = instValid && instReady;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         decValid <= 1'b0;
      end else if (instReady) begin
         decValid <= instValid;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         dec <= decNext;
      end
   end

   // A stalled result stays put until execute takes it
   decHoldA: assert property (@(posedge clk) disable iff (!rstN)
      decValid && !decReady |=> decValid && $stable(dec))
      else $error("wiscDecode output changed under back-pressure");

endmodule

// ==== test/tb_wiscDecode.sv ====
// WISC decode stage testbench
// Replays the decode pattern file with random back-pressure, then
// finishes the file at full speed to check the one-cycle latency
`timescale 1ns/100ps

`include "wisc_consts.svh"

module tb_wiscDecode;

   localparam int numSteps = 31;
   localparam int numCols  = 10;
   localparam int fastFrom = 20;
   localparam int maxWait  = 200;

   logic                    clk;
   logic                    rstN;
   logic                    instValid;
   logic                    instReady;
   isaPkg::instU            inst;
   logic                    wbEn;
   logic [`WISC_RSEL_W-1:0] wbSel;
   logic [`WISC_DATA_W-1:0] wbData;
   logic                    decValid;
   logic                    decReady;
   ctrlPkg::decOpT          dec;

   // One row of numCols words per step
   logic [31:0]    patMem [numSteps*numCols];
   logic [31:0]    rngState;
   logic           fastPhase;
   int             curStep;
   int             cycle;
   int             doneCnt;
   int             waitCnt;
   int             row;
   // Accepted instructions still in flight
   int             accStep [$];
   int             accCycle [$];
   bit             accFast [$];
   bit             prevStall;
   ctrlPkg::decOpT prevDec;

   wiscDecode u_wiscDecode (
      .clk       (clk),
      .rstN      (rstN),
      .instValid (instValid),
      .instReady (instReady),
      .inst      (inst),
      .wbEn      (wbEn),
      .wbSel     (wbSel),
      .wbData    (wbData),
      .decValid  (decValid),
      .decReady  (decReady),
      .dec       (dec)
   );

   always #4 clk = ~clk;

   always @(posedge clk) cycle++;

   function automatic logic [31:0] nextRandom(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic stopWithFailure(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic compareValue(input string name, input logic [127:0] expVal,
                               input logic [127:0] gotVal);
      if (expVal !== gotVal) begin
         stopWithFailure($sformatf("Error %s expected %0h got %0h", name, expVal, gotVal));
      end
   endtask

   // Destination register picked by the expected regDst selector
   // regDst sits just above the two regSrc bits of the control word
   function automatic logic [`WISC_RSEL_W-1:0] expectedDest(input logic [31:0] ctrlWord,
                                                            input logic [15:0] instWord);
      case (ctrlWord[3:2])
         2'b00:   return instWord[4:2];
         2'b01:   return instWord[10:8];
         2'b10:   return instWord[7:5];
         default: return `WISC_RSEL_W'(`WISC_NREGS - 1);
      endcase
   endfunction

   // Optional writeback, then hold the instruction until it is taken
   task automatic runStep(input int s);
      int         base;
      logic [1:0] mode;
      base = s * numCols;
      mode = patMem[base][1:0];
      wbSel  = patMem[base+1][`WISC_RSEL_W-1:0];
      wbData = patMem[base+2][`WISC_DATA_W-1:0];
      if (mode == 2'd1) begin
         wbEn = 1'b1;
         @(posedge clk);
         #1;
      end
      // Mode 2 writes in the accepting cycle, so the read is bypassed
      wbEn      = (mode == 2'd2);
      inst      = patMem[base+3][15:0];
      instValid = 1'b1;
      curStep   = s;
      waitCnt   = 0;
      @(negedge clk);
      while (!instReady) begin
         if (fastPhase) begin
            stopWithFailure("Instruction stalled while decReady was held high");
         end
         waitCnt++;
         if (waitCnt > maxWait) begin
            stopWithFailure("Timed out waiting for instReady");
         end
         @(negedge clk);
      end
      @(posedge clk);
      #1;
      instValid = 1'b0;
      wbEn      = 1'b0;
   endtask

   // Random back-pressure until the full speed part
   always @(posedge clk) begin
      #1;
      rngState = nextRandom(rngState);
      decReady = fastPhase || rngState[0];
   end

   ////////////////////
   // Monitor
   ////////////////////
   always @(negedge clk) begin
      if (rstN) begin
         // Held result must not move
         if (prevStall) begin
            compareValue("decValid", 1, decValid);
            compareValue("dec", prevDec, dec);
         end
         prevStall = decValid && !decReady;
         prevDec   = dec;
         if (decValid && decReady) begin
            if (accStep.size() == 0) begin
               stopWithFailure("Decoded result came out with no instruction accepted");
            end
            row = accStep.pop_front() * numCols;
            if (accFast.pop_front()) begin
               compareValue("latency", 1, cycle - accCycle.pop_front());
            end else begin
               void'(accCycle.pop_front());
            end
            compareValue("ctrl", patMem[row+4], dec.ctrl);
            compareValue("r1Data", patMem[row+5], dec.r1Data);
            compareValue("r2Data", patMem[row+6], dec.r2Data);
            compareValue("imm5Ext", patMem[row+7], dec.imm5Ext);
            compareValue("imm8Ext", patMem[row+8], dec.imm8Ext);
            compareValue("imm11Ext", patMem[row+9], dec.imm11Ext);
            compareValue("rsSel", patMem[row+3][10:8], dec.rsSel);
            compareValue("rdSel", expectedDest(patMem[row+4], patMem[row+3][15:0]),
                         dec.rdSel);
            doneCnt++;
         end
         if (instValid && instReady) begin
            accStep.push_back(curStep);
            accCycle.push_back(cycle);
            accFast.push_back(fastPhase);
         end
      end
   end

   initial begin
      clk       = 1'b0;
      rstN      = 1'b0;
      instValid = 1'b0;
      inst      = '0;
      wbEn      = 1'b0;
      wbSel     = '0;
      wbData    = '0;
      decReady  = 1'b0;
      rngState  = 32'h61f6;
      fastPhase = 1'b0;
      curStep   = 0;
      cycle     = 0;
      doneCnt   = 0;
      prevStall = 1'b0;
      $readmemh("test/decode_patterns.txt", patMem);
      if ($isunknown(patMem[numSteps*numCols-1])) begin
         stopWithFailure("Pattern file is missing or shorter than expected");
      end
      repeat (2) @(posedge clk);
      #1;
      rstN = 1'b1;
      compareValue("decValid", 0, decValid);
      for (int s = 0; s < numSteps; s++) begin
         // Last part runs with decReady held high
         if (s == fastFrom) begin
            fastPhase = 1'b1;
            decReady  = 1'b1;
         end
         runStep(s);
      end
      waitCnt = 0;
      while (doneCnt < numSteps) begin
         waitCnt++;
         if (waitCnt > maxWait) begin
            stopWithFailure("Timed out waiting for the last decoded results");
         end
         @(negedge clk);
      end
      $display("=== PASS ===");
      $finish;
   end

endmodule

// ==== test/decode_patterns.txt ====
// mode(0 none, 1 writeback first, 2 writeback with inst) wbSel wbData inst
// then expected ctrl r1Data r2Data imm5Ext imm8Ext imm11Ext, all hex
0 0 0000 DBA4 20D02 0000 0000 0004 FFA4 03A4
1 3 1234 DBA9 34D02 1234 0000 0009 FFA9 03A9
1 5 BEEF DBB2 20DC2 1234 BEEF FFF2 FFB2 03B2
2 6 0F0F DEC7 2CD42 0F0F 0F0F 0007 FFC7 FEC7
0 0 0000 D661 20842 0F0F 1234 0001 0061 FE61
0 0 0000 433F 2011A 1234 0000 FFFF 003F 033F
0 0 0000 4D50 3451A BEEF 0000 FFF0 0050 FD50
0 0 0000 5155 209DA 0000 0000 0015 0055 0155
0 0 0000 58FA 2CD5A 0000 0000 001A 00FA 00FA
0 0 0000 6580 83132 BEEF 0000 0000 FF80 FD80
0 0 0000 6B7F 83532 1234 1234 FFFF 007F 037F
0 0 0000 76F0 83932 0F0F 0000 FFF0 FFF0 FEF0
0 0 0000 7805 83D32 0000 0000 0005 0005 0005
0 0 0000 83A3 40116 1234 BEEF 0003 FFA3 03A3
0 0 0000 8D3E 20519 BEEF 0000 FFFE 003E FD3E
0 0 0000 9E71 60D16 0F0F 1234 FFF1 0071 FE71
0 0 0000 92C3 20927 0000 0F0F 0003 00C3 02C3
0 0 0000 C49A 20127 0000 0000 FFFA FF9A FC9A
0 0 0000 A38F 2001A 1234 0000 000F FF8F 038F
0 0 0000 BDC4 20CDA BEEF 0F0F 0004 FFC4 FDC4
0 0 0000 CD08 20523 BEEF 0000 0008 0008 FD08
0 0 0000 E3B8 34302 1234 BEEF FFF8 FFB8 03B8
0 0 0000 EE64 34702 0F0F 1234 0004 0064 FE64
0 0 0000 F5DC 2CB02 BEEF 0F0F FFFC FFDC FDDC
0 0 0000 F868 20F02 0000 1234 0008 0068 0068
0 0 0000 2400 10012C 0000 0000 0000 0000 FC00
0 0 0000 3123 12092C 0000 0000 0003 0023 0123
0 0 0000 2B10 8052C 1234 0000 FFF0 0010 0310
0 0 0000 3EFE A0D2C 0F0F 0000 FFFE FFFE FEFE
0 0 0000 0800 00522 0000 0000 0000 0000 0000
0 0 0000 0560 00122 BEEF 1234 0000 0060 FD60

// ==== wiscDecode.f ====
+incdir+rtl
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/ctrlDecoder.sv
rtl/regFile.sv
rtl/wiscDecode.sv
test/tb_wiscDecode.sv

// ==== Bender.yml ====
package:
  name: wiscDecode

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isaPkg.sv
      - rtl/ctrlPkg.sv
      - rtl/ctrlDecoder.sv
      - rtl/regFile.sv
      - rtl/wiscDecode.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_wiscDecode.sv
